// ==== logic/ex_settings.svh ====
// Build-time constants for the execute slice
// XLEN is fixed at 32 and MISA_VALUE is a 32-bit word
// CSR addresses follow the machine-mode map
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data path width
`define XLEN 32

// Machine CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305
`define CSR_MISA     12'h301
`define CSR_MCYCLE   12'hB00

// RV32I misa with MXL of 1 and only the I bit set
`define MISA_VALUE 32'h4000_0100

`endif

// ==== logic/ex_pkg.sv ====
// Instruction encodings for the execute slice
// Opcodes are bits 6:2 of a 32-bit instruction
// Compressed encodings are not described here
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Major opcodes, instruction bits 6:2
  ////////////////////////////////////////
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_OPIMM  = 5'b00100;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_SYSTEM = 5'b11100;

  // Bits 1:0 of every 32-bit instruction
  localparam logic [1:0] LEN_32 = 2'b11;

  ////////////////////////////////////////
  // funct3 codes
  ////////////////////////////////////////
  // OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // SYSTEM, CSR access
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // funct7 codes
  localparam logic [6:0] F7_BASE = 7'b0000000;
  // Selects SUB and SRA/SRAI
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  ////////////////////////////////////////
  // Instruction word, two views
  ////////////////////////////////////////
  typedef union packed {
    // R-type view for ALU decode
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [4:0] opcode;
      logic [1:0] len;
    } r;
    // I-type and CSR view
    struct packed {
      logic [11:0] imm_csr;
      logic [4:0]  rs1_uimm;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [4:0]  opcode;
      logic [1:0]  len;
    } i;
  } instr_t;

endpackage

`default_nettype wire

// ==== logic/ex_operands.sv ====
// Operand builder for the execute slice
// Purely combinational, operands follow id_instr in the same cycle
// Only I, U and CSR zimm immediates are formed
`default_nettype none

`include "ex_settings.svh"

module ex_operands (
  input  wire  [`XLEN-1:0]     id_pc,
  input  wire  ex_pkg::instr_t id_instr,
  input  wire  [`XLEN-1:0]     rs1_val,
  input  wire  [`XLEN-1:0]     rs2_val,
  output logic [`XLEN-1:0]     op_a,
  output logic [`XLEN-1:0]     op_b
);

  ////////////////////////////////////////
  // Immediate extraction
  ////////////////////////////////////////

  // Upper 20 bits of the word, before the low zeros
  logic signed [19:0]      u_field;
  // U immediate as a signed 32-bit value
  logic signed [31:0]      u_word;
  logic [`XLEN-1:0]        imm_i;
  logic [`XLEN-1:0]        imm_u;
  logic [`XLEN-1:0]        imm_z;
  // CSR forms with the zimm source
  logic                    csr_imm_form;

  // I immediate from instruction bits 31:20
  assign imm_i = `XLEN'($signed(id_instr.i.imm_csr));

  // U immediate from bits 31:12
  assign u_field = {id_instr.i.imm_csr, id_instr.i.rs1_uimm, id_instr.i.funct3};
  assign u_word  = {u_field, 12'h000};
  // Sign carries into the upper half on wider data paths
  assign imm_u   = `XLEN'(u_word);

  // zimm sits in the rs1 slot, never sign extended
  assign imm_z = `XLEN'(id_instr.i.rs1_uimm);

  // RWI, RSI and RCI all have funct3 bit 2 set
  always_comb begin
    case (id_instr.i.funct3)
      ex_pkg::F3_CSRRWI,
      ex_pkg::F3_CSRRSI,
      ex_pkg::F3_CSRRCI: csr_imm_form = 1'b1;
      default:           csr_imm_form = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////

  always_comb begin
    // Register operands by default
    op_a = rs1_val;
    op_b = rs2_val;
    case (id_instr.i.opcode)
      ex_pkg::OPC_LUI: begin
        // Sum in the ALU yields the bare immediate
        op_a = '0;
        op_b = imm_u;
      end
      ex_pkg::OPC_AUIPC: begin
        op_a = id_pc;
        op_b = imm_u;
      end
      ex_pkg::OPC_OPIMM: begin
        op_b = imm_i;
      end
      ex_pkg::OPC_SYSTEM: begin
        // Register CSR forms keep rs1_val on op_a
        if (csr_imm_form) begin
          op_b = imm_z;
        end
      end
      default: begin
        op_a = rs1_val;
        op_b = rs2_val;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ex_alu.sv ====
// Execute-stage ALU with CSR command generation
// One cycle latency, a high ex_stall freezes alu_r and alu_bubble
// Unsupported encodings retire as bubbles, their alu_r is not meaningful
// No W operations, shift amount is log2(XLEN) bits of op_b
`default_nettype none

`include "ex_settings.svh"

module ex_alu (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  ex_stall,
  input  wire  [`XLEN-1:0]     id_pc,
  input  wire                  id_bubble,
  input  wire  ex_pkg::instr_t id_instr,
  input  wire  [`XLEN-1:0]     op_a,
  input  wire  [`XLEN-1:0]     op_b,
  input  wire  [`XLEN-1:0]     csr_rval,
  output logic [`XLEN-1:0]     alu_r,
  output logic                 alu_bubble,
  output logic [11:0]          csr_addr,
  output logic                 csr_we,
  output logic [`XLEN-1:0]     csr_wval
);

  localparam int SBITS = $clog2(`XLEN);

  logic [4:0]        opcode;
  logic [2:0]        funct3;
  logic              f7_base;
  logic              f7_alt;
  logic              instr_32;
  logic [SBITS-1:0]  shamt;
  // Next result and decode hit
  logic [`XLEN-1:0]  alu_next;
  logic              known;
  // CSR decode
  logic              csr_f3;
  logic              is_csr;
  logic [`XLEN-1:0]  csr_src;

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  assign opcode   = id_instr.r.opcode;
  assign funct3   = id_instr.r.funct3;
  assign f7_base  = (id_instr.r.funct7 == ex_pkg::F7_BASE);
  assign f7_alt   = (id_instr.r.funct7 == ex_pkg::F7_ALT);
  // Compressed words fall out as unknown
  assign instr_32 = (id_instr.r.len == ex_pkg::LEN_32);
  assign shamt    = op_b[SBITS-1:0];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    alu_next = '0;
    known    = 1'b0;
    if (instr_32) begin
      case (opcode)
        // LUI sees op_a of zero, so one adder serves both
        ex_pkg::OPC_LUI,
        ex_pkg::OPC_AUIPC: begin
          alu_next = op_a + op_b;
          known    = 1'b1;
        end
        // Link address only, target is resolved elsewhere
        ex_pkg::OPC_JAL: begin
          alu_next = id_pc + `XLEN'd4;
          known    = 1'b1;
        end
        ex_pkg::OPC_JALR: begin
          alu_next = id_pc + `XLEN'd4;
          known    = (funct3 == 3'b000);
        end
        ex_pkg::OPC_OPIMM,
        ex_pkg::OPC_OP: begin
          case (funct3)
            ex_pkg::F3_ADD: begin
              // SUB exists in the register form only
              if (opcode == ex_pkg::OPC_OP && f7_alt) begin
                alu_next = op_a - op_b;
              end else begin
                alu_next = op_a + op_b;
              end
              known = (opcode == ex_pkg::OPC_OPIMM) || f7_base || f7_alt;
            end
            ex_pkg::F3_SLL: begin
              alu_next = op_a << shamt;
              known    = f7_base;
            end
            ex_pkg::F3_SLT: begin
              alu_next = ($signed(op_a) < $signed(op_b)) ? `XLEN'd1 : `XLEN'd0;
              known    = (opcode == ex_pkg::OPC_OPIMM) || f7_base;
            end
            ex_pkg::F3_SLTU: begin
              alu_next = (op_a < op_b) ? `XLEN'd1 : `XLEN'd0;
              known    = (opcode == ex_pkg::OPC_OPIMM) || f7_base;
            end
            ex_pkg::F3_XOR: begin
              alu_next = op_a ^ op_b;
              known    = (opcode == ex_pkg::OPC_OPIMM) || f7_base;
            end
            ex_pkg::F3_SR: begin
              // funct7 alt picks arithmetic shift in both forms
              if (f7_alt) begin
                alu_next = $signed(op_a) >>> shamt;
              end else begin
                alu_next = op_a >> shamt;
              end
              known = f7_base || f7_alt;
            end
            ex_pkg::F3_OR: begin
              alu_next = op_a | op_b;
              known    = (opcode == ex_pkg::OPC_OPIMM) || f7_base;
            end
            default: begin
              // AND
              alu_next = op_a & op_b;
              known    = (opcode == ex_pkg::OPC_OPIMM) || f7_base;
            end
          endcase
        end
        ex_pkg::OPC_SYSTEM: begin
          // Old CSR value, ECALL and friends stay unknown
          alu_next = csr_rval;
          known    = csr_f3;
        end
        default: begin
          alu_next = '0;
          known    = 1'b0;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Result and bubble registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      alu_r      <= '0;
      alu_bubble <= 1'b1;
    end else if (!ex_stall) begin
      alu_r      <= alu_next;
      alu_bubble <= known ? id_bubble : 1'b1;
    end
  end

  ////////////////////////////////////////
  // CSR command
  ////////////////////////////////////////

  // Address straight from the I-type immediate slot
  assign csr_addr = id_instr.i.imm_csr;

  always_comb begin
    case (funct3)
      ex_pkg::F3_CSRRW, ex_pkg::F3_CSRRS, ex_pkg::F3_CSRRC,
      ex_pkg::F3_CSRRWI, ex_pkg::F3_CSRRSI, ex_pkg::F3_CSRRCI: csr_f3 = 1'b1;
      default: csr_f3 = 1'b0;
    endcase
  end

  assign is_csr  = instr_32 && (opcode == ex_pkg::OPC_SYSTEM) && csr_f3;
  // Immediate forms bring zimm on op_b, register forms rs1 on op_a
  assign csr_src = funct3[2] ? op_b : op_a;

  // Write lands on the edge that registers the old value
  always_comb begin
    csr_we   = 1'b0;
    csr_wval = csr_src;
    if (is_csr && !id_bubble && !ex_stall) begin
      case (funct3)
        ex_pkg::F3_CSRRW, ex_pkg::F3_CSRRWI: begin
          csr_we   = 1'b1;
          csr_wval = csr_src;
        end
        ex_pkg::F3_CSRRS, ex_pkg::F3_CSRRSI: begin
          // Zero source means read only
          csr_we   = |csr_src;
          csr_wval = csr_rval | csr_src;
        end
        default: begin
          // Clear forms
          csr_we   = |csr_src;
          csr_wval = csr_rval & ~csr_src;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ex_csr_file.sv ====
// Machine CSR block with mscratch, mtvec, misa and mcycle
// Reads are combinational, writes happen on any edge with csr_we high
// Unknown addresses read zero and drop writes, misa is read only
// mtvec supports direct mode only
`default_nettype none

`include "ex_settings.svh"

module ex_csr_file (
  input  wire               clk,
  input  wire               rstn,
  input  wire  [11:0]       csr_addr,
  input  wire               csr_we,
  input  wire  [`XLEN-1:0]  csr_wval,
  output logic [`XLEN-1:0]  csr_rval
);

  logic [`XLEN-1:0] mscratch;
  // Base only, mode bits are always zero
  logic [`XLEN-1:2] mtvec_base;
  logic [`XLEN-1:0] mcycle;
  // Per-register write strobes
  logic             wr_mscratch;
  logic             wr_mtvec;
  logic             wr_mcycle;

  assign wr_mscratch = csr_we && (csr_addr == `CSR_MSCRATCH);
  assign wr_mtvec    = csr_we && (csr_addr == `CSR_MTVEC);
  assign wr_mcycle   = csr_we && (csr_addr == `CSR_MCYCLE);

  ////////////////////////////////////////
  // Register updates
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mscratch   <= '0;
      mtvec_base <= '0;
    end else begin
      if (wr_mscratch) begin
        mscratch <= csr_wval;
      end
      if (wr_mtvec) begin
        mtvec_base <= csr_wval[`XLEN-1:2];
      end
    end
  end

  // Free-running, ignores stall, a write wins over the increment
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mcycle <= '0;
    end else if (wr_mcycle) begin
      mcycle <= csr_wval;
    end else begin
      mcycle <= mcycle + `XLEN'd1;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  always_comb begin
    case (csr_addr)
      `CSR_MSCRATCH: csr_rval = mscratch;
      `CSR_MTVEC:    csr_rval = {mtvec_base, 2'b00};
      `CSR_MISA:     csr_rval = `MISA_VALUE;
      `CSR_MCYCLE:   csr_rval = mcycle;
      default:       csr_rval = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
// Execute stage top, operands, ALU and CSR block
// Inputs come straight from decode, no handshake
// Result and bubble appear one edge after an unstalled instruction
`default_nettype none

`include "ex_settings.svh"

module ex_stage (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  ex_stall,
  input  wire  [`XLEN-1:0]     id_pc,
  input  wire                  id_bubble,
  input  wire  ex_pkg::instr_t id_instr,
  input  wire  [`XLEN-1:0]     rs1_val,
  input  wire  [`XLEN-1:0]     rs2_val,
  output logic [`XLEN-1:0]     alu_r,
  output logic                 alu_bubble
);

  // Operand path
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  // CSR command and read data
  logic [11:0]      csr_addr;
  logic             csr_we;
  logic [`XLEN-1:0] csr_wval;
  logic [`XLEN-1:0] csr_rval;

  ex_operands u_operands (
    .id_pc    (id_pc),
    .id_instr (id_instr),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  ex_alu u_alu (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_pc      (id_pc),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .op_a       (op_a),
    .op_b       (op_b),
    .csr_rval   (csr_rval),
    .alu_r      (alu_r),
    .alu_bubble (alu_bubble),
    .csr_addr   (csr_addr),
    .csr_we     (csr_we),
    .csr_wval   (csr_wval)
  );

  ex_csr_file u_csr_file (
    .clk      (clk),
    .rstn     (rstn),
    .csr_addr (csr_addr),
    .csr_we   (csr_we),
    .csr_wval (csr_wval),
    .csr_rval (csr_rval)
  );

endmodule

`default_nettype wire

// ==== testbench/ex_stage_assert.sv ====
// Bound checker for the execute stage outputs
// Reference model assumes XLEN of 32 and the machine CSR map in the settings header
// Only mscratch is mirrored, mtvec and mcycle values are not predicted
// Counts failures in fail_count so the testbench can stop on the first one
`default_nettype none

`include "ex_settings.svh"

module ex_stage_assert (
  input wire              clk,
  input wire              rstn,
  input wire              ex_stall,
  input wire [`XLEN-1:0]  id_pc,
  input wire              id_bubble,
  input wire [31:0]       id_instr,
  input wire [`XLEN-1:0]  rs1_val,
  input wire [`XLEN-1:0]  rs2_val,
  input wire [`XLEN-1:0]  alu_r,
  input wire              alu_bubble
);

  int unsigned fail_count = 0;

  // Mirror of mscratch
  logic [31:0] shadow;
  // Expected result of the instruction seen last edge
  logic [31:0] exp_r;
  logic        exp_bub;
  logic        chk_val;
  // Outputs as they stood before the last edge
  logic [31:0] held_r;
  logic        held_bub;
  // Live mcycle read, CSRRS with x0
  logic        mcyc_rd;

  ////////////////////////////////////////
  // Reference decode
  ////////////////////////////////////////

  // Encodings the stage must accept
  function automatic logic ref_known(input logic [31:0] ins);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       res;
    f3  = ins[14:12];
    f7  = ins[31:25];
    res = 1'b0;
    if (ins[1:0] == 2'b11) begin
      case (ins[6:2])
        ex_pkg::OPC_LUI, ex_pkg::OPC_AUIPC, ex_pkg::OPC_JAL: res = 1'b1;
        ex_pkg::OPC_JALR: res = (f3 == 3'b000);
        ex_pkg::OPC_OPIMM: begin
          if (f3 == 3'b001) begin
            res = (f7 == 7'h00);
          end else if (f3 == 3'b101) begin
            res = (f7 == 7'h00) || (f7 == 7'h20);
          end else begin
            res = 1'b1;
          end
        end
        ex_pkg::OPC_OP: res = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        // ECALL, EBREAK and funct3 100 are not CSR accesses
        ex_pkg::OPC_SYSTEM: res = (f3 != 3'b000) && (f3 != 3'b100);
        default: res = 1'b0;
      endcase
    end
    return res;
  endfunction

  // Architectural result from the ISA rules
  function automatic logic [31:0] ref_value(input logic [31:0] ins, input logic [31:0] pc,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] scratch);
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] y;
    logic [4:0]  sh;
    logic [31:0] res;
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    y     = (ins[6:2] == ex_pkg::OPC_OPIMM) ? imm_i : b;
    sh    = y[4:0];
    res   = '0;
    case (ins[6:2])
      ex_pkg::OPC_LUI:   res = imm_u;
      ex_pkg::OPC_AUIPC: res = pc + imm_u;
      ex_pkg::OPC_JAL, ex_pkg::OPC_JALR: res = pc + 32'd4;
      ex_pkg::OPC_OP, ex_pkg::OPC_OPIMM: begin
        case (ins[14:12])
          3'b000: res = (ins[6:2] == ex_pkg::OPC_OP && ins[30]) ? a - y : a + y;
          3'b001: res = a << sh;
          3'b010: res = {31'b0, $signed(a) < $signed(y)};
          3'b011: res = {31'b0, a < y};
          3'b100: res = a ^ y;
          3'b101: begin
            if (ins[30]) begin
              res = $signed(a) >>> sh;
            end else begin
              res = a >> sh;
            end
          end
          3'b110: res = a | y;
          default: res = a & y;
        endcase
      end
      ex_pkg::OPC_SYSTEM: begin
        case (ins[31:20])
          `CSR_MSCRATCH: res = scratch;
          `CSR_MISA:     res = `MISA_VALUE;
          default:       res = '0;
        endcase
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // mscratch after a CSR access, zero source gives the old value
  function automatic logic [31:0] scratch_after(input logic [31:0] ins, input logic [31:0] a,
                                                input logic [31:0] old);
    logic [31:0] src;
    src = ins[14] ? {27'b0, ins[19:15]} : a;
    case (ins[13:12])
      2'b01:   return src;
      2'b10:   return old | src;
      2'b11:   return old & ~src;
      default: return old;
    endcase
  endfunction

  // CSRs whose contents are not mirrored
  function automatic logic csr_unmodeled(input logic [31:0] ins);
    return (ins[6:2] == ex_pkg::OPC_SYSTEM) &&
           (ins[31:20] == `CSR_MTVEC || ins[31:20] == `CSR_MCYCLE);
  endfunction

  assign mcyc_rd = !ex_stall && !id_bubble && (id_instr[31:20] == `CSR_MCYCLE) &&
                   (id_instr[19:12] == {5'd0, ex_pkg::F3_CSRRS}) &&
                   (id_instr[6:0] == {ex_pkg::OPC_SYSTEM, 2'b11});

  ////////////////////////////////////////
  // Model state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      shadow   <= '0;
      exp_r    <= '0;
      exp_bub  <= 1'b1;
      chk_val  <= 1'b0;
      held_r   <= '0;
      held_bub <= 1'b1;
    end else begin
      exp_r    <= ref_value(id_instr, id_pc, rs1_val, rs2_val, shadow);
      exp_bub  <= id_bubble || !ref_known(id_instr);
      chk_val  <= !id_bubble && ref_known(id_instr) && !csr_unmodeled(id_instr);
      held_r   <= alu_r;
      held_bub <= alu_bubble;
      // Stalled or bubbled CSR ops leave mscratch alone
      if (!ex_stall && !id_bubble && id_instr[31:20] == `CSR_MSCRATCH &&
          id_instr[6:0] == {ex_pkg::OPC_SYSTEM, 2'b11}) begin
        shadow <= scratch_after(id_instr, rs1_val, shadow);
      end
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  a_result: assert property (@(posedge clk) disable iff (!rstn)
      !$past(ex_stall) && chk_val |-> alu_r == exp_r)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] t=%0t alu_r expected %h actual %h", $time, $sampled(exp_r),
             $sampled(alu_r));
    end

  a_bubble: assert property (@(posedge clk) disable iff (!rstn)
      !$past(ex_stall) |-> alu_bubble == exp_bub)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] t=%0t alu_bubble expected %b actual %b", $time, $sampled(exp_bub),
             $sampled(alu_bubble));
    end

  a_hold_r: assert property (@(posedge clk) disable iff (!rstn)
      $past(ex_stall) |-> alu_r == held_r)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] t=%0t alu_r under stall expected %h actual %h", $time,
             $sampled(held_r), $sampled(alu_r));
    end

  a_hold_bubble: assert property (@(posedge clk) disable iff (!rstn)
      $past(ex_stall) |-> alu_bubble == held_bub)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] t=%0t alu_bubble under stall expected %b actual %b", $time,
             $sampled(held_bub), $sampled(alu_bubble));
    end

  // Back-to-back mcycle reads are one count apart
  a_mcycle: assert property (@(posedge clk) disable iff (!rstn)
      $past(mcyc_rd) && $past(mcyc_rd, 2) |-> alu_r == held_r + 32'd1)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] t=%0t alu_r from mcycle expected %h actual %h", $time,
             $sampled(held_r) + 32'd1, $sampled(alu_r));
    end

endmodule

bind ex_stage ex_stage_assert u_assert (
  .clk        (clk),
  .rstn       (rstn),
  .ex_stall   (ex_stall),
  .id_pc      (id_pc),
  .id_bubble  (id_bubble),
  .id_instr   (id_instr),
  .rs1_val    (rs1_val),
  .rs2_val    (rs2_val),
  .alu_r      (alu_r),
  .alu_bubble (alu_bubble)
);

`default_nettype wire

// ==== testbench/ex_stage_tb.sv ====
// Directed testbench for the execute stage
// Result checking lives in the bound assertion module
// Stalled instructions are not re-presented, the list simply moves on
// PC advances by 4 for every presented word
`default_nettype none

`include "ex_settings.svh"

module ex_stage_tb;

  localparam int RST_CYCLES     = 3;
  localparam int STEP_COUNT     = 49;
  // Generous budget over list plus reset
  localparam int TIMEOUT_CYCLES = 4 * (STEP_COUNT + RST_CYCLES);

  logic              clk;
  logic              rstn;
  logic              ex_stall;
  logic [`XLEN-1:0]  id_pc;
  logic              id_bubble;
  logic [31:0]       id_instr;
  logic [`XLEN-1:0]  rs1_val;
  logic [`XLEN-1:0]  rs2_val;
  logic [`XLEN-1:0]  alu_r;
  logic              alu_bubble;

  logic              done;
  logic              fail_printed;
  logic [`XLEN-1:0]  next_pc;
  int                cycles = 0;

  ex_stage u_ex_stage (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_pc      (id_pc),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .alu_r      (alu_r),
    .alu_bubble (alu_bubble)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Encoders, rs1 x1, rs2 x2, rd x3
  ////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, ex_pkg::OPC_OP, 2'b11};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc, 2'b11};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] opc);
    return {imm, 5'd3, opc, 2'b11};
  endfunction

  // src is the rs1 index or the zimm
  function automatic logic [31:0] csr_instr(input logic [11:0] addr, input logic [4:0] src,
                                            input logic [2:0] f3);
    return {addr, src, f3, 5'd3, ex_pkg::OPC_SYSTEM, 2'b11};
  endfunction

  ////////////////////////////////////////
  // Drive and stop helpers
  ////////////////////////////////////////

  task automatic present(input logic [31:0] instr, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic bubble, input logic stall);
    @(posedge clk);
    id_instr  <= instr;
    rs1_val   <= a;
    rs2_val   <= b;
    id_bubble <= bubble;
    ex_stall  <= stall;
    id_pc     <= next_pc;
    next_pc = next_pc + `XLEN'd4;
  endtask

  task automatic stop_on_failure();
    fail_printed = 1'b1;
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expect_reset_value(input string name, input logic [31:0] exp_val,
                                    input logic [31:0] act_val);
    assert (act_val == exp_val) else begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  // Cycle budget
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  // Stop at the first bound assertion failure
  always @(negedge clk) begin
    if (u_ex_stage.u_assert.fail_count != 0) begin
      $display("A bound assertion on the execute stage outputs failed");
      stop_on_failure();
    end
  end

  ////////////////////////////////////////
  // Directed stimulus
  ////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    ex_stall     = 1'b0;
    id_pc        = '0;
    id_bubble    = 1'b1;
    id_instr     = '0;
    rs1_val      = '0;
    rs2_val      = '0;
    done         = 1'b0;
    fail_printed = 1'b0;
    next_pc      = `XLEN'h1000;

    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    expect_reset_value("alu_r", 32'h0, alu_r);
    expect_reset_value("alu_bubble", 32'h1, {31'b0, alu_bubble});
    @(posedge clk);
    rstn <= 1'b1;

    // Register ALU ops
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_ADD), 32'h0000_0005, 32'h0000_0007, 0, 0);
    present(r_type(ex_pkg::F7_ALT, ex_pkg::F3_ADD), 32'h0000_0005, 32'h0000_0007, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_AND), 32'hF0F0_1234, 32'h0FF0_FFFF, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_OR), 32'hF0F0_1234, 32'h0FF0_FFFF, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_XOR), 32'hF0F0_1234, 32'h0FF0_FFFF, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_SLT), 32'hFFFF_FFFE, 32'h0000_0003, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_SLTU), 32'hFFFF_FFFE, 32'h0000_0003, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_SLL), 32'h8000_0001, 32'h0000_0024, 0, 0);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_SR), 32'h8000_0010, 32'h0000_0004, 0, 0);
    present(r_type(ex_pkg::F7_ALT, ex_pkg::F3_SR), 32'h8000_0010, 32'h0000_0004, 0, 0);
    // Immediate ALU ops
    present(i_type(12'hFFF, ex_pkg::F3_ADD, ex_pkg::OPC_OPIMM), 32'd10, 32'h0, 0, 0);
    present(i_type(12'h800, ex_pkg::F3_SLT, ex_pkg::OPC_OPIMM), 32'hFFFF_F000, 32'h0, 0, 0);
    present(i_type(12'hFFF, ex_pkg::F3_SLTU, ex_pkg::OPC_OPIMM), 32'd5, 32'h0, 0, 0);
    present(i_type(12'h0F0, ex_pkg::F3_XOR, ex_pkg::OPC_OPIMM), 32'h1234_5678, 32'h0, 0, 0);
    present(i_type(12'h801, ex_pkg::F3_OR, ex_pkg::OPC_OPIMM), 32'h1234_5678, 32'h0, 0, 0);
    present(i_type(12'h7F0, ex_pkg::F3_AND, ex_pkg::OPC_OPIMM), 32'h1234_5678, 32'h0, 0, 0);
    present(i_type(12'h003, ex_pkg::F3_SLL, ex_pkg::OPC_OPIMM), 32'h1000_0001, 32'h0, 0, 0);
    present(i_type(12'h008, ex_pkg::F3_SR, ex_pkg::OPC_OPIMM), 32'h8000_0000, 32'h0, 0, 0);
    present(i_type(12'h408, ex_pkg::F3_SR, ex_pkg::OPC_OPIMM), 32'h8000_0000, 32'h0, 0, 0);
    // Upper immediates and links
    present(u_type(20'hABCDE, ex_pkg::OPC_LUI), 32'h1111_1111, 32'h0, 0, 0);
    present(u_type(20'h00012, ex_pkg::OPC_AUIPC), 32'h0, 32'h0, 0, 0);
    present(u_type(20'h00100, ex_pkg::OPC_JAL), 32'h0, 32'h0, 0, 0);
    present(i_type(12'h010, 3'b000, ex_pkg::OPC_JALR), 32'h0000_4000, 32'h0, 0, 0);
    // Bubble in, load opcode, M-extension funct7
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_ADD), 32'd1, 32'd2, 1, 0);
    present(32'h0000_2083, 32'd1, 32'd2, 0, 0);
    present(r_type(7'h01, ex_pkg::F3_ADD), 32'd3, 32'd4, 0, 0);
    // mscratch, register and immediate forms
    present(csr_instr(`CSR_MSCRATCH, 5'd1, ex_pkg::F3_CSRRW), 32'h1234_5678, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd1, ex_pkg::F3_CSRRS), 32'h0000_0F00, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd1, ex_pkg::F3_CSRRC), 32'h0000_0070, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd0, ex_pkg::F3_CSRRSI), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd0, ex_pkg::F3_CSRRCI), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'h0F, ex_pkg::F3_CSRRCI), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'h15, ex_pkg::F3_CSRRSI), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'h05, ex_pkg::F3_CSRRWI), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MSCRATCH, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    // Stalled write and a bubbled ALU op, then read back
    present(csr_instr(`CSR_MSCRATCH, 5'd1, ex_pkg::F3_CSRRW), 32'hDEAD_BEEF, 32'h0, 0, 1);
    present(r_type(ex_pkg::F7_BASE, ex_pkg::F3_ADD), 32'd9, 32'd9, 1, 1);
    present(csr_instr(`CSR_MSCRATCH, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    // misa read only, unknown CSR reads zero
    present(csr_instr(`CSR_MISA, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MISA, 5'd1, ex_pkg::F3_CSRRW), 32'hFFFF_FFFF, 32'h0, 0, 0);
    present(csr_instr(`CSR_MISA, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    present(csr_instr(12'h7C0, 5'd1, ex_pkg::F3_CSRRW), 32'h0000_5555, 32'h0, 0, 0);
    present(csr_instr(12'h7C0, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    // Two mcycle reads in a row
    present(csr_instr(`CSR_MCYCLE, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    present(csr_instr(`CSR_MCYCLE, 5'd0, ex_pkg::F3_CSRRS), 32'h0, 32'h0, 0, 0);
    // ECALL is not a CSR access
    present(32'h0000_0073, 32'h0, 32'h0, 0, 0);

    // Drain the last result
    present(32'h0, '0, '0, 1, 0);
    present(32'h0, '0, '0, 1, 0);
    @(negedge clk);
    done = 1'b1;
    if (u_ex_stage.u_assert.fail_count != 0) begin
      $display("Bound assertions reported %0d failures", u_ex_stage.u_assert.fail_count);
      stop_on_failure();
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

  // Covers stops that bypass the normal ending
  final begin
    if (!done && !fail_printed) begin
      $display("Simulation failed");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/ex_pkg.sv
logic/ex_operands.sv
logic/ex_alu.sv
logic/ex_csr_file.sv
logic/ex_stage.sv
testbench/ex_stage_assert.sv
testbench/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
